// File: i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // ========================================
    // Bus widths
    // ========================================
    localparam int i2c_addr_w = 7;
    localparam int data_w = 8;

    typedef logic [i2c_addr_w-1:0] i2c_addr_t;
    typedef logic [data_w-1:0] data_t;

    // ========================================
    // Master command flags
    // ========================================
    // Same order as the loose cmd_* ports on the master
    typedef struct packed {
        logic start;
        logic read;
        logic write;
        logic stop;
    } cmd_t;

    // Write transfer, stop after the data stream
    localparam cmd_t cmd_wr_stop = '{start: 1'b1, read: 1'b0, write: 1'b1, stop: 1'b1};
    // Register pointer write, bus kept for the repeated start
    localparam cmd_t cmd_wr_hold = '{start: 1'b1, read: 1'b0, write: 1'b1, stop: 1'b0};
    // Single byte read, then stop
    localparam cmd_t cmd_rd_stop = '{start: 1'b1, read: 1'b1, write: 1'b0, stop: 1'b1};
    localparam cmd_t cmd_none = '0;

endpackage

`default_nettype wire

// File: bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // ========================================
    // UART request format
    // ========================================
    // Byte 0 is {addr[6:0], rw}, byte 1 is {conv, reg_addr[6:0]}
    localparam int rw_bit = 0;
    localparam int conv_bit = 7;

    typedef struct packed {
        i2c_pkg::i2c_addr_t addr;
        logic               rw;
        logic               conv;
        logic [6:0]         reg_addr;
    } req_t;

    // Register byte sent first on the I2C data stream
    function automatic i2c_pkg::data_t reg_byte(input req_t r);
        return {r.conv, r.reg_addr};
    endfunction

    // ========================================
    // Write configuration table
    // ========================================
    localparam int cfg_len = 13;

    // Test pattern, swap in real sensor settings here
    localparam i2c_pkg::data_t cfg_table [cfg_len] = '{
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd5, 8'd6, 8'd7, 8'd8,
        8'd9, 8'd10, 8'd11, 8'd12,
        8'd13
    };

    // Register byte plus the whole table
    localparam int wr_len = cfg_len + 1;
    localparam int wr_cnt_w = $clog2(wr_len);

endpackage

`default_nettype wire

// File: cmd_parser.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_parser (
    input  wire                clk,
    input  wire                rstn,
    input  wire i2c_pkg::data_t rx_tdata,
    input  wire                rx_tvalid,
    output logic               rx_tready,
    output bridge_pkg::req_t   req,
    output logic               req_valid,
    input  wire                req_ready
);

    import bridge_pkg::*;

    // 0 expects the address byte, 1 the register byte
    logic reg_phase;
    logic rx_fire;

    // Stall the UART only while a finished request is pending
    assign rx_tready = !req_valid;
    assign rx_fire = rx_tvalid && rx_tready;

    // ========================================
    // Phase and request valid
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg_phase <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            if (rx_fire) begin
                reg_phase <= !reg_phase;
            end

            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end else if (rx_fire && reg_phase) begin
                req_valid <= 1'b1;
            end
        end
    end

    // ========================================
    // Field capture
    // ========================================
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            if (!reg_phase) begin
                req.addr <= rx_tdata[7:1];
                req.rw <= rx_tdata[rw_bit];
            end else begin
                req.conv <= rx_tdata[conv_bit];
                req.reg_addr <= rx_tdata[6:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: stream_skid.sv
`timescale 1ns/1ns
`default_nettype none

module stream_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk,
    input  wire           rstn,
    input  wire payload_t in_data,
    input  wire           in_valid,
    output logic          in_ready,
    output payload_t      out_data,
    output logic          out_valid,
    input  wire           out_ready
);

    // Second entry, filled only when the output is stalled
    payload_t skid_data;
    logic     skid_valid;
    logic     in_fire;
    logic     out_free;

    assign in_ready = !skid_valid;
    assign in_fire = in_valid && in_ready;
    // Output register empty or being drained this cycle
    assign out_free = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_free) begin
                // Skid entry is older, it goes out first
                out_valid <= skid_valid || in_valid;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_valid) begin
                out_data <= in_data;
            end
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: i2c_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_sequencer (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire bridge_pkg::req_t req,
    input  wire                   req_valid,
    output logic                  req_ready,
    output i2c_pkg::i2c_addr_t    cmd_addr,
    output logic                  cmd_start,
    output logic                  cmd_read,
    output logic                  cmd_write,
    output logic                  cmd_stop,
    output logic                  cmd_valid,
    input  wire                   cmd_ready,
    output i2c_pkg::data_t        wr_tdata,
    output logic                  wr_tvalid,
    output logic                  wr_tlast,
    input  wire                   wr_tready
);

    import i2c_pkg::*;
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_cmd,
        st_data,
        st_cmd_rd
    } state_t;

    state_t              state;
    req_t                cur;
    logic [wr_cnt_w-1:0] byte_cnt;
    logic [wr_cnt_w-1:0] cfg_idx;
    cmd_t                cmd_sel;
    logic                req_fire;
    logic                cmd_fire;
    logic                wr_fire;

    assign req_ready = (state == st_idle);
    assign req_fire = req_valid && req_ready;
    assign cmd_fire = cmd_valid && cmd_ready;
    assign wr_fire = wr_tvalid && wr_tready;

    // ========================================
    // Command outputs
    // ========================================
    always_comb begin
        case (state)
            st_cmd:    cmd_sel = cur.rw ? cmd_wr_hold : cmd_wr_stop;
            st_cmd_rd: cmd_sel = cmd_rd_stop;
            default:   cmd_sel = cmd_none;
        endcase
    end

    assign cmd_valid = (state == st_cmd) || (state == st_cmd_rd);
    assign cmd_addr = cur.addr;
    assign cmd_start = cmd_sel.start;
    assign cmd_read = cmd_sel.read;
    assign cmd_write = cmd_sel.write;
    assign cmd_stop = cmd_sel.stop;

    // ========================================
    // Write data stream
    // ========================================
    // Byte 0 is the register byte, table entries follow
    assign cfg_idx = byte_cnt - wr_cnt_w'(1);
    assign wr_tdata = (byte_cnt == '0) ? reg_byte(cur) : cfg_table[cfg_idx];
    assign wr_tvalid = (state == st_data);
    // A read only sends the register pointer
    assign wr_tlast = wr_tvalid &&
        (cur.rw ? (byte_cnt == '0) : (byte_cnt == wr_cnt_w'(wr_len - 1)));

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_fire) begin
                        state <= st_cmd;
                    end
                end
                st_cmd: begin
                    if (cmd_fire) begin
                        state <= st_data;
                        byte_cnt <= '0;
                    end
                end
                st_data: begin
                    if (wr_fire) begin
                        if (wr_tlast) begin
                            state <= cur.rw ? st_cmd_rd : st_idle;
                        end else begin
                            byte_cnt <= byte_cnt + wr_cnt_w'(1);
                        end
                    end
                end
                st_cmd_rd: begin
                    if (cmd_fire) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Held for the whole request
    always_ff @(posedge clk) begin
        if (req_fire) begin
            cur <= req;
        end
    end

endmodule

`default_nettype wire

// File: uart_i2c_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module uart_i2c_bridge (
    input  wire                     clk,
    input  wire                     rstn,
    // UART receive stream
    input  wire i2c_pkg::data_t     rx_tdata,
    input  wire                     rx_tvalid,
    output logic                    rx_tready,
    // UART transmit stream
    output i2c_pkg::data_t          tx_tdata,
    output logic                    tx_tvalid,
    input  wire                     tx_tready,
    // I2C master command
    output i2c_pkg::i2c_addr_t      cmd_addr,
    output logic                    cmd_start,
    output logic                    cmd_read,
    output logic                    cmd_write,
    output logic                    cmd_stop,
    output logic                    cmd_valid,
    input  wire                     cmd_ready,
    // I2C write data
    output i2c_pkg::data_t          wr_tdata,
    output logic                    wr_tvalid,
    output logic                    wr_tlast,
    input  wire                     wr_tready,
    // I2C read data, one byte per read so rd_tlast carries nothing new
    input  wire i2c_pkg::data_t     rd_tdata,
    input  wire                     rd_tvalid,
    input  wire                     rd_tlast,
    output logic                    rd_tready
);

    import i2c_pkg::*;
    import bridge_pkg::*;

    req_t req_raw;
    logic req_raw_valid;
    logic req_raw_ready;
    req_t req_buf;
    logic req_buf_valid;
    logic req_buf_ready;

    // ========================================
    // Request path
    // ========================================
    cmd_parser u_parser (
        .clk       (clk),
        .rstn      (rstn),
        .rx_tdata  (rx_tdata),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .req       (req_raw),
        .req_valid (req_raw_valid),
        .req_ready (req_raw_ready)
    );

    // Holds one more request while the sequencer is busy
    stream_skid #(.payload_t(req_t)) u_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .in_data   (req_raw),
        .in_valid  (req_raw_valid),
        .in_ready  (req_raw_ready),
        .out_data  (req_buf),
        .out_valid (req_buf_valid),
        .out_ready (req_buf_ready)
    );

    i2c_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req_buf),
        .req_valid (req_buf_valid),
        .req_ready (req_buf_ready),
        .cmd_addr  (cmd_addr),
        .cmd_start (cmd_start),
        .cmd_read  (cmd_read),
        .cmd_write (cmd_write),
        .cmd_stop  (cmd_stop),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .wr_tdata  (wr_tdata),
        .wr_tvalid (wr_tvalid),
        .wr_tlast  (wr_tlast),
        .wr_tready (wr_tready)
    );

    // ========================================
    // Read response path
    // ========================================
    stream_skid #(.payload_t(data_t)) u_rd_buf (
        .clk       (clk),
        .rstn      (rstn),
        .in_data   (rd_tdata),
        .in_valid  (rd_tvalid),
        .in_ready  (rd_tready),
        .out_data  (tx_tdata),
        .out_valid (tx_tvalid),
        .out_ready (tx_tready)
    );

endmodule

`default_nettype wire

// File: bridge_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module bridge_assertions #(
    parameter type payload_t = logic
) (
    input wire           clk,
    input wire           rstn,
    input wire           valid,
    input wire           ready,
    input wire payload_t data
);

    int fail_cnt = 0;

    // ========================================
    // Ready/valid hold rules
    // ========================================
    // Sender keeps valid up while stalled
    a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
        valid && !ready |=> valid) else begin
        $error("valid dropped before ready in %m");
        fail_cnt++;
    end

    a_data_hold: assert property (@(posedge clk) disable iff (!rstn)
        valid && !ready |=> $stable(data)) else begin
        $error("payload changed before ready in %m");
        fail_cnt++;
    end

endmodule

// Command fields and write data of the sequencer
bind i2c_sequencer bridge_assertions #(.payload_t(logic [10:0])) u_cmd_chk (
    .clk   (clk),
    .rstn  (rstn),
    .valid (cmd_valid),
    .ready (cmd_ready),
    .data  ({cmd_addr, cmd_start, cmd_read, cmd_write, cmd_stop})
);

bind i2c_sequencer bridge_assertions #(.payload_t(logic [8:0])) u_wr_chk (
    .clk   (clk),
    .rstn  (rstn),
    .valid (wr_tvalid),
    .ready (wr_tready),
    .data  ({wr_tdata, wr_tlast})
);

// Output side of both buffers
bind stream_skid bridge_assertions #(.payload_t(payload_t)) u_out_chk (
    .clk   (clk),
    .rstn  (rstn),
    .valid (out_valid),
    .ready (out_ready),
    .data  (out_data)
);

`default_nettype wire

// File: tb_uart_i2c_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_i2c_bridge;

    import i2c_pkg::*;
    import bridge_pkg::*;

    logic        clk = 1'b0;
    logic        rstn = 1'b0;
    data_t       rx_tdata = '0;
    logic        rx_tvalid = 1'b0;
    logic        rx_tready;
    data_t       tx_tdata;
    logic        tx_tvalid;
    logic        tx_tready = 1'b1;
    i2c_addr_t   cmd_addr;
    logic        cmd_start;
    logic        cmd_read;
    logic        cmd_write;
    logic        cmd_stop;
    logic        cmd_valid;
    logic        cmd_ready = 1'b0;
    data_t       wr_tdata;
    logic        wr_tvalid;
    logic        wr_tlast;
    logic        wr_tready = 1'b0;
    data_t       rd_tdata = '0;
    logic        rd_tvalid = 1'b0;
    logic        rd_tlast = 1'b0;
    logic        rd_tready;

    // I2C master model state
    i2c_addr_t   cmd_addr_q[$];
    logic [3:0]  cmd_flag_q[$];
    data_t       wr_q[$];
    logic        last_q[$];
    data_t       tx_q[$];
    int          rx_cnt = 0;
    int          rd_req_cnt = 0;
    int          rd_sent_cnt = 0;
    logic        stall_en = 1'b0;
    data_t       rsp_byte = '0;
    logic [31:0] rng_state = 32'd36169;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    logic        timed_out = 1'b0;

    uart_i2c_bridge UUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ========================================
    // I2C master model
    // ========================================
    always @(posedge clk) begin
        if (rx_tvalid && rx_tready) begin
            rx_cnt++;
        end
        if (cmd_valid && cmd_ready) begin
            cmd_addr_q.push_back(cmd_addr);
            cmd_flag_q.push_back({cmd_start, cmd_read, cmd_write, cmd_stop});
            if (cmd_read) begin
                rd_req_cnt++;
            end
        end
        if (wr_tvalid && wr_tready) begin
            wr_q.push_back(wr_tdata);
            last_q.push_back(wr_tlast);
        end
        if (rd_tvalid && rd_tready) begin
            rd_sent_cnt++;
        end
        if (tx_tvalid && tx_tready) begin
            tx_q.push_back(tx_tdata);
        end
    end

    // Ready pattern and one response byte per read command
    always @(negedge clk) begin
        logic [31:0] r;
        r = xorshift32();
        cmd_ready = !stall_en || r[3];
        wr_tready = !stall_en || r[11];
        rd_tvalid = (rd_sent_cnt < rd_req_cnt);
        rd_tdata = rsp_byte;
        rd_tlast = 1'b1;
    end

    // ========================================
    // Compare and report
    // ========================================
    task automatic compare_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_addr(input string name, input i2c_addr_t exp, input i2c_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ========================================
    // Stimulus and expected traffic
    // ========================================
    task automatic send_byte(input data_t b);
        int n;
        int t;
        n = rx_cnt;
        t = 0;
        rx_tdata = b;
        rx_tvalid = 1'b1;
        while (!timed_out && rx_cnt == n) begin
            @(negedge clk);
            t++;
            if (t == 200) begin
                timed_out = 1'b1;
                note_failure("The bridge never accepted a UART byte");
            end
        end
        rx_tvalid = 1'b0;
    endtask

    task automatic send_request(input i2c_addr_t addr, input logic rw, input logic conv,
                                input logic [6:0] reg_addr);
        send_byte({addr, rw});
        send_byte({conv, reg_addr});
    endtask

    // Polls the model until enough transfers have been collected
    task automatic wait_for_traffic(input int n_cmd, input int n_wr, input int n_tx);
        int t;
        t = 0;
        while (!timed_out && (cmd_addr_q.size() < n_cmd || wr_q.size() < n_wr ||
                tx_q.size() < n_tx)) begin
            @(negedge clk);
            t++;
            if (t == 3000) begin
                timed_out = 1'b1;
                note_failure("The expected I2C commands, write bytes or UART byte never arrived");
            end
        end
    endtask

    task automatic pop_cmd(input i2c_addr_t addr, input logic [3:0] flags);
        logic [3:0] got;
        if (cmd_addr_q.size() == 0) begin
            note_failure("An expected I2C command is missing");
            return;
        end
        got = cmd_flag_q.pop_front();
        compare_addr("cmd_addr", addr, cmd_addr_q.pop_front());
        compare_flag("cmd_start", flags[3], got[3]);
        compare_flag("cmd_read", flags[2], got[2]);
        compare_flag("cmd_write", flags[1], got[1]);
        compare_flag("cmd_stop", flags[0], got[0]);
    endtask

    // Register byte first, then table entry k holds k
    task automatic pop_stream(input data_t reg_b, input int n);
        data_t exp;
        for (int i = 0; i < n; i++) begin
            if (wr_q.size() == 0) begin
                note_failure("The I2C write stream ended early");
                return;
            end
            exp = (i == 0) ? reg_b : data_t'(i);
            compare_data("wr_tdata", exp, wr_q.pop_front());
            compare_flag("wr_tlast", i == n - 1, last_q.pop_front());
        end
    endtask

    task automatic expect_write(input i2c_addr_t addr, input logic conv, input logic [6:0] r);
        pop_cmd(addr, 4'b1011);
        pop_stream({conv, r}, 14);
    endtask

    task automatic expect_read(input i2c_addr_t addr, input logic conv, input logic [6:0] r,
                               input data_t rsp);
        pop_cmd(addr, 4'b1010);
        pop_stream({conv, r}, 1);
        pop_cmd(addr, 4'b1101);
        if (tx_q.size() == 0) begin
            note_failure("No read byte reached the UART transmit stream");
        end else begin
            compare_data("tx_tdata", rsp, tx_q.pop_front());
        end
    endtask

    // Quiet period catches repeated or stray transfers
    task automatic end_test(input string name, input int err0);
        repeat (10) @(negedge clk);
        if (cmd_addr_q.size() != 0 || wr_q.size() != 0 || tx_q.size() != 0) begin
            note_failure("Extra I2C or UART transfers appeared after the expected ones");
        end
        cmd_addr_q.delete();
        cmd_flag_q.delete();
        wr_q.delete();
        last_q.delete();
        tx_q.delete();
        tests++;
        if (errors != err0) begin
            failed_tests++;
            $display("%s: FAIL", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic reset_values();
        int err0;
        err0 = errors;
        compare_flag("cmd_valid", 1'b0, cmd_valid);
        compare_flag("wr_tvalid", 1'b0, wr_tvalid);
        compare_flag("wr_tlast", 1'b0, wr_tlast);
        compare_flag("tx_tvalid", 1'b0, tx_tvalid);
        compare_flag("rx_tready", 1'b1, rx_tready);
        compare_flag("rd_tready", 1'b1, rd_tready);
        end_test("reset_values", err0);
    endtask

    task automatic write_request();
        int err0;
        err0 = errors;
        send_request(7'h48, 1'b0, 1'b1, 7'h15);
        wait_for_traffic(1, 14, 0);
        expect_write(7'h48, 1'b1, 7'h15);
        end_test("write_request", err0);
    endtask

    task automatic read_request();
        int err0;
        err0 = errors;
        rsp_byte = 8'ha7;
        send_request(7'h1d, 1'b1, 1'b0, 7'h42);
        wait_for_traffic(2, 1, 1);
        expect_read(7'h1d, 1'b0, 7'h42, 8'ha7);
        end_test("read_request", err0);
    endtask

    task automatic stalled_write();
        int err0;
        err0 = errors;
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        send_request(7'h2a, 1'b0, 1'b0, 7'h33);
        wait_for_traffic(1, 14, 0);
        expect_write(7'h2a, 1'b0, 7'h33);
        @(posedge clk);
        stall_en = 1'b0;
        @(negedge clk);
        end_test("stalled_write", err0);
    endtask

    // Read queued in the request buffer behind a running write
    task automatic back_to_back();
        int err0;
        err0 = errors;
        rsp_byte = 8'h3c;
        send_request(7'h50, 1'b0, 1'b0, 7'h01);
        send_request(7'h51, 1'b1, 1'b1, 7'h7f);
        wait_for_traffic(3, 15, 1);
        expect_write(7'h50, 1'b0, 7'h01);
        expect_read(7'h51, 1'b1, 7'h7f, 8'h3c);
        end_test("back_to_back", err0);
    endtask

    task automatic tx_backpressure();
        int err0;
        int t;
        err0 = errors;
        t = 0;
        rsp_byte = 8'h5a;
        tx_tready = 1'b0;
        send_request(7'h0f, 1'b1, 1'b0, 7'h09);
        while (!timed_out && !tx_tvalid) begin
            @(negedge clk);
            t++;
            if (t == 500) begin
                timed_out = 1'b1;
                note_failure("The read byte never reached tx_tvalid");
            end
        end
        repeat (6) begin
            compare_flag("tx_tvalid", 1'b1, tx_tvalid);
            compare_data("tx_tdata", 8'h5a, tx_tdata);
            @(negedge clk);
        end
        tx_tready = 1'b1;
        wait_for_traffic(2, 1, 1);
        expect_read(7'h0f, 1'b0, 7'h09, 8'h5a);
        end_test("tx_backpressure", err0);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        reset_values();
        if (!timed_out) write_request();
        if (!timed_out) read_request();
        if (!timed_out) stalled_write();
        if (!timed_out) back_to_back();
        if (!timed_out) tx_backpressure();
        errors += UUT.u_seq.u_cmd_chk.fail_cnt + UUT.u_seq.u_wr_chk.fail_cnt +
                  UUT.u_req_buf.u_out_chk.fail_cnt + UUT.u_rd_buf.u_out_chk.fail_cnt;
        $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
i2c_pkg.sv
bridge_pkg.sv
cmd_parser.sv
stream_skid.sv
i2c_sequencer.sv
uart_i2c_bridge.sv
bridge_assertions.sv
tb_uart_i2c_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module tb_uart_i2c_bridge -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
